// ==== all.f ====
+incdir+logic
logic/cpuPkg.sv
logic/stageReg.sv
logic/fetchUnit.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/execUnit.sv
logic/memAccess.sv
logic/hazardCtrl.sv
logic/cpuTop.sv
bench/cpuTb.sv

// ==== bench/cpuTb.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpuTb;

    localparam logic [31:0] HALT_PC = 32'h0000_00fc;   // last word of the program
    localparam int RUN_TIMEOUT = 3000;

    logic                        clk;
    logic                        reset;
    logic [`CPU_XLEN-1:0]        instrAddr;
    logic [`CPU_XLEN-1:0]        instrData;
    logic                        dataEn;
    logic [3:0]                  dataWen;
    logic [`CPU_XLEN-1:0]        dataAddr;
    logic [`CPU_XLEN-1:0]        dataWdata;
    logic [`CPU_XLEN-1:0]        dataRdata;
    logic [`CPU_XLEN-1:0]        debugWbPc;
    logic                        debugWbWen;
    logic [`CPU_REG_ADDR_W-1:0]  debugWbNum;
    logic [`CPU_XLEN-1:0]        debugWbData;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] modelMem [64];
    logic [31:0] modelRegs [32];
    logic [31:0] lfsr;

    logic [31:0] expWbPc[$];
    logic [4:0]  expWbNum[$];
    logic [31:0] expWbData[$];
    logic [31:0] expStAddr[$];
    logic [3:0]  expStWen[$];
    logic [31:0] expStData[$];
    logic [31:0] expLdAddr[$];

    int wbIdx = 0;
    int stIdx = 0;
    int ldIdx = 0;
    int sinceReset = 0;
    int mismatches = 0;
    int failures = 0;

    cpuTop u_dut (
        .clk(clk), .reset(reset),
        .instrAddr(instrAddr), .instrData(instrData),
        .dataEn(dataEn), .dataWen(dataWen), .dataAddr(dataAddr),
        .dataWdata(dataWdata), .dataRdata(dataRdata),
        .debugWbPc(debugWbPc), .debugWbWen(debugWbWen),
        .debugWbNum(debugWbNum), .debugWbData(debugWbData)
    );

    always #4 clk = ~clk;

    // both memories answer in the same cycle
    assign instrData = (instrAddr[31:8] == 24'h0) ? imem[instrAddr[7:2]] : 32'h0;
    assign dataRdata = dmem[dataAddr[7:2]];

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at time %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic nextBit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = 32'h0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], nextBit()};
        end
        return v;
    endfunction

    function automatic logic [4:0] pickReg();
        return 5'(32'd1 + randBits(3) % 32'd7);   // $1..$7 only
    endfunction

    function automatic logic [5:0] pickFunct();
        case (randBits(3) % 32'd6)
            32'd0:   return 6'h21;
            32'd1:   return 6'h23;
            32'd2:   return 6'h24;
            32'd3:   return 6'h25;
            32'd4:   return 6'h26;
            default: return 6'h2a;
        endcase
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] mergeLanes(input logic [31:0] old, input logic [31:0] wdata,
                                               input logic [3:0] wen);
        logic [31:0] w;
        w = old;
        for (int l = 0; l < 4; l++) begin
            if (wen[l]) w[8*l +: 8] = wdata[8*l +: 8];
        end
        return w;
    endfunction

    function automatic logic [31:0] fillWord(input int i);
        return (32'h9e37_79b9 * 32'(i + 1)) ^ (32'(i) << 20);
    endfunction

    task automatic buildProgram();
        logic [31:0] kind;
        logic [4:0]  rs, rt, rd;
        logic [15:0] imm, off;
        int          skip;
        for (int i = 0; i < 63; i++) begin
            kind = randBits(4);
            rs = pickReg();
            rt = pickReg();
            rd = pickReg();
            imm = 16'(randBits(16));
            off = 16'(randBits(8));   // 256 byte window off $0
            case (kind)
                32'd0, 32'd1, 32'd2, 32'd3, 32'd4: imem[i] = rType(pickFunct(), rs, rt, rd);
                32'd6:  imem[i] = iType(6'h0d, rs, rd, imm);
                32'd7:  imem[i] = iType(6'h0f, 5'd0, rd, imm);
                32'd8:  imem[i] = iType(6'h23, 5'd0, rd, off & 16'h00fc);
                32'd9:  imem[i] = iType(6'h20, 5'd0, rd, off);
                32'd10: imem[i] = iType(6'h24, 5'd0, rd, off);
                32'd11: imem[i] = iType(6'h2b, 5'd0, rt, off & 16'h00fc);
                32'd12: imem[i] = iType(6'h28, 5'd0, rt, off);
                32'd13, 32'd14: begin
                    if (randBits(1) == 32'd1) rt = rs;   // equal operands half the time
                    skip = 1 + int'(randBits(2) % 32'd3);
                    if (i + 1 + skip > 63) skip = 62 - i;
                    imem[i] = iType((kind == 32'd13) ? 6'h04 : 6'h05, rs, rt, 16'(skip));
                end
                default: imem[i] = iType(6'h09, rs, rd, imm);
            endcase
        end
        imem[63] = iType(6'h04, 5'd0, 5'd0, 16'hffff);   // halt loop of beq to itself
    endtask

    // sequential model of the same program
    task automatic runModel();
        logic [31:0] pc, nextPc, ins, a, b, simm, addr, res, word;
        logic [7:0]  byteVal;
        logic [4:0]  rd;
        logic        wr;
        int          steps;
        pc = `CPU_RESET_PC;
        steps = 0;
        while (pc != HALT_PC && steps < 1000) begin
            ins = imem[pc[7:2]];
            a = modelRegs[ins[25:21]];
            b = modelRegs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            addr = a + simm;
            word = modelMem[addr[7:2]];
            byteVal = word[8*addr[1:0] +: 8];
            nextPc = pc + 32'd4;
            rd = ins[20:16];
            wr = 1'b1;
            res = 32'h0;
            case (ins[31:26])
                6'h00: begin
                    rd = ins[15:11];
                    case (ins[5:0])
                        6'h21:   res = a + b;
                        6'h23:   res = a - b;
                        6'h24:   res = a & b;
                        6'h25:   res = a | b;
                        6'h26:   res = a ^ b;
                        6'h2a:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                6'h09: res = addr;
                6'h0d: res = a | {16'h0, ins[15:0]};
                6'h0f: res = {ins[15:0], 16'h0};
                6'h23: res = word;
                6'h20: res = {{24{byteVal[7]}}, byteVal};
                6'h24: res = {24'h0, byteVal};
                6'h2b, 6'h28: begin
                    wr = 1'b0;
                    expStAddr.push_back(addr);
                    if (ins[31:26] == 6'h2b) begin
                        expStWen.push_back(4'b1111);
                        expStData.push_back(b);
                    end else begin
                        expStWen.push_back(4'b0001 << addr[1:0]);
                        expStData.push_back({4{b[7:0]}});
                    end
                    modelMem[addr[7:2]] = mergeLanes(word, expStData[$], expStWen[$]);
                end
                6'h04, 6'h05: begin
                    wr = 1'b0;
                    if ((a == b) == (ins[31:26] == 6'h04)) nextPc = pc + 32'd4 + (simm << 2);
                end
                default: wr = 1'b0;
            endcase
            if (ins[31:26] inside {6'h20, 6'h23, 6'h24}) begin
                expLdAddr.push_back(addr);
            end
            if (wr && rd != 5'd0) begin
                modelRegs[rd] = res;
                expWbPc.push_back(pc);
                expWbNum.push_back(rd);
                expWbData.push_back(res);
            end
            pc = nextPc;
            steps++;
        end
    endtask

    always @(posedge clk) begin
        if (!reset && dataEn === 1'b1 && dataWen != 4'b0000) begin
            dmem[dataAddr[7:2]] <= mergeLanes(dmem[dataAddr[7:2]], dataWdata, dataWen);
        end
    end

    // mid-cycle sampling of trace and data port
    always @(negedge clk) begin
        if (reset || sinceReset == 0) begin
            checkEq(32'(debugWbWen), 32'd0, "debugWbWen around reset");
            checkEq(32'(dataEn), 32'd0, "dataEn around reset");
            checkEq(instrAddr, `CPU_RESET_PC, "instrAddr around reset");
        end
        if (!reset) begin
            sinceReset++;
            if (debugWbWen === 1'b1) begin
                if (wbIdx >= expWbPc.size()) begin
                    failures++;
                    $display("unexpected register write from pc %h at time %0t",
                             debugWbPc, $time);
                end else begin
                    checkEq(debugWbPc, expWbPc[wbIdx], $sformatf("write %0d pc", wbIdx));
                    checkEq(32'(debugWbNum), 32'(expWbNum[wbIdx]),
                            $sformatf("write %0d reg", wbIdx));
                    checkEq(debugWbData, expWbData[wbIdx], $sformatf("write %0d data", wbIdx));
                    wbIdx++;
                end
            end
            if (dataEn === 1'b1 && dataWen != 4'b0000) begin
                if (stIdx >= expStAddr.size()) begin
                    failures++;
                    $display("unexpected store to %h at time %0t", dataAddr, $time);
                end else begin
                    checkEq(dataAddr, expStAddr[stIdx], $sformatf("store %0d addr", stIdx));
                    checkEq(32'(dataWen), 32'(expStWen[stIdx]),
                            $sformatf("store %0d lanes", stIdx));
                    checkEq(dataWdata, expStData[stIdx], $sformatf("store %0d data", stIdx));
                    stIdx++;
                end
            end
            if (dataEn === 1'b1 && dataWen == 4'b0000) begin
                if (ldIdx >= expLdAddr.size()) begin
                    failures++;
                    $display("unexpected load from %h at time %0t", dataAddr, $time);
                end else begin
                    checkEq(dataAddr, expLdAddr[ldIdx], $sformatf("load %0d addr", ldIdx));
                    ldIdx++;
                end
            end
        end
    end

    initial begin
        int   cycles;
        logic finished;
        clk = 1'b0;
        reset = 1'b1;
        lfsr = 32'h1a6e;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'h0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fillWord(i);
            modelMem[i] = fillWord(i);
        end
        buildProgram();
        runModel();
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        cycles = 0;
        finished = 1'b0;
        while (!finished && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            finished = wbIdx == expWbPc.size() && stIdx == expStAddr.size() &&
                       ldIdx == expLdAddr.size() && instrAddr == HALT_PC;
        end
        if (!finished) begin
            failures++;
            $display("timeout: core did not reach the halt loop");
            $display("seen %0d of %0d writes, %0d of %0d stores, %0d of %0d loads",
                     wbIdx, expWbPc.size(), stIdx, expStAddr.size(),
                     ldIdx, expLdAddr.size());
        end else begin
            cycles = 0;
            while (cycles < 8) begin   // let stray writes show up
                @(posedge clk);
                cycles++;
            end
            for (int i = 0; i < 64; i++) begin
                checkEq(dmem[i], modelMem[i], $sformatf("data word %0d", i));
            end
        end

        $display("%0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== logic/cpuPkg.sv ====
`include "cpu_config.svh"

package cpuPkg;

    typedef logic [`CPU_XLEN-1:0] wordT;
    typedef logic [`CPU_REG_ADDR_W-1:0] regIdxT;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_SB      = 6'h28,
        OP_SW      = 6'h2b
    } opT;

    // function field of SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
    } aluOpT;

    // MEM_NONE must stay zero, bubbles are all-zero payloads
    typedef enum logic [2:0] {
        MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW, MEM_SB
    } memOpT;

    typedef enum logic [1:0] {
        BR_NONE, BR_BEQ, BR_BNE
    } branchOpT;

    typedef enum logic [1:0] {
        FWD_REG, FWD_MEM, FWD_WB
    } fwdSelT;

    typedef struct packed {
        wordT pc;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        wordT     pc;
        wordT     rsVal;
        wordT     rtVal;
        regIdxT   rsIdx;
        regIdxT   rtIdx;
        regIdxT   destIdx;
        logic     regWrite;
        wordT     imm;
        wordT     branchTarget;
        logic     useImm;
        aluOpT    aluOp;
        memOpT    memOp;
        branchOpT branchOp;
    } idExT;

    typedef struct packed {
        wordT   pc;
        wordT   aluResult;
        wordT   storeVal;   // forwarded rt for SW/SB
        regIdxT destIdx;
        logic   regWrite;
        memOpT  memOp;
    } exMemT;

    typedef struct packed {
        wordT   pc;
        wordT   result;
        regIdxT destIdx;
        logic   regWrite;
    } memWbT;

endpackage

// ==== logic/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
    input  logic       clk,
    input  logic       reset,
    output wordT       instrAddr,
    input  wordT       instrData,
    output logic       dataEn,
    output logic [3:0] dataWen,
    output wordT       dataAddr,
    output wordT       dataWdata,
    input  wordT       dataRdata,
    output wordT       debugWbPc,
    output logic       debugWbWen,
    output regIdxT     debugWbNum,
    output wordT       debugWbData
);

    ifIdT  ifIdIn, ifId;
    idExT  idExIn, idEx;
    exMemT exMemIn, exMem;
    memWbT memWbIn, memWb;

    regIdxT   rsIdx, rtIdx, destIdx;
    logic     regWrite, useImm;
    wordT     imm, idBranchTarget, rsVal, rtVal;
    aluOpT    aluOp;
    memOpT    memOp;
    branchOpT branchOp;

    wordT   aluResult, storeVal, branchTarget, memResult;
    logic   branchTaken, exIsLoad;
    logic   stallF, stallD, flushD, flushE;
    fwdSelT fwdA, fwdB;

    fetchUnit u_fetch (
        .clk(clk), .reset(reset), .stallF(stallF),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .instrAddr(instrAddr)
    );

    assign ifIdIn = '{pc: instrAddr, instr: instrData};

    stageReg #(.payloadT(ifIdT)) u_ifId (
        .clk(clk), .reset(reset), .stall(stallD), .flush(flushD),
        .bubble('0), .dataIn(ifIdIn), .dataOut(ifId)
    );

    instrDecoder u_decode (
        .instr(ifId.instr), .pc(ifId.pc),
        .rsIdx(rsIdx), .rtIdx(rtIdx), .destIdx(destIdx), .regWrite(regWrite),
        .imm(imm), .branchTarget(idBranchTarget), .useImm(useImm),
        .aluOp(aluOp), .memOp(memOp), .branchOp(branchOp)
    );

    regFile u_regs (
        .clk(clk), .reset(reset),
        .rsIdx(rsIdx), .rtIdx(rtIdx), .rsVal(rsVal), .rtVal(rtVal),
        .wrEn(memWb.regWrite), .wrIdx(memWb.destIdx), .wrData(memWb.result)
    );

    assign idExIn = '{pc: ifId.pc, rsVal: rsVal, rtVal: rtVal, rsIdx: rsIdx, rtIdx: rtIdx,
                      destIdx: destIdx, regWrite: regWrite, imm: imm,
                      branchTarget: idBranchTarget, useImm: useImm, aluOp: aluOp,
                      memOp: memOp, branchOp: branchOp};

    stageReg #(.payloadT(idExT)) u_idEx (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(flushE),
        .bubble('0), .dataIn(idExIn), .dataOut(idEx)
    );

    execUnit u_exec (
        .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
        .memFwd(exMem.aluResult), .wbFwd(memWb.result),
        .aluResult(aluResult), .storeVal(storeVal),
        .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    assign exIsLoad = idEx.memOp inside {MEM_LW, MEM_LB, MEM_LBU};
    assign exMemIn  = '{pc: idEx.pc, aluResult: aluResult, storeVal: storeVal,
                       destIdx: idEx.destIdx, regWrite: idEx.regWrite, memOp: idEx.memOp};

    stageReg #(.payloadT(exMemT)) u_exMem (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0),
        .bubble('0), .dataIn(exMemIn), .dataOut(exMem)
    );

    memAccess u_mem (
        .exMem(exMem), .dataEn(dataEn), .dataWen(dataWen), .dataAddr(dataAddr),
        .dataWdata(dataWdata), .dataRdata(dataRdata), .result(memResult)
    );

    assign memWbIn = '{pc: exMem.pc, result: memResult,
                       destIdx: exMem.destIdx, regWrite: exMem.regWrite};

    stageReg #(.payloadT(memWbT)) u_memWb (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0),
        .bubble('0), .dataIn(memWbIn), .dataOut(memWb)
    );

    hazardCtrl u_hazard (
        .idRs(rsIdx), .idRt(rtIdx),
        .exDest(idEx.destIdx), .exRegWrite(idEx.regWrite), .exIsLoad(exIsLoad),
        .exRs(idEx.rsIdx), .exRt(idEx.rtIdx),
        .memDest(exMem.destIdx), .memRegWrite(exMem.regWrite),
        .wbDest(memWb.destIdx), .wbRegWrite(memWb.regWrite),
        .branchTaken(branchTaken),
        .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
        .fwdA(fwdA), .fwdB(fwdB)
    );

    // trace shows what the register file takes this cycle
    assign debugWbPc   = memWb.pc;
    assign debugWbWen  = memWb.regWrite;
    assign debugWbNum  = memWb.destIdx;
    assign debugWbData = memWb.result;

endmodule

// ==== logic/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and address width
`define CPU_XLEN 32

// architectural register file
`define CPU_REG_COUNT 32
`define CPU_REG_ADDR_W 5

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== logic/execUnit.sv ====
`timescale 1ns/1ps

module execUnit import cpuPkg::*; (
    input  idExT   idEx,
    input  fwdSelT fwdA,
    input  fwdSelT fwdB,
    input  wordT   memFwd,
    input  wordT   wbFwd,
    output wordT   aluResult,
    output wordT   storeVal,
    output logic   branchTaken,
    output wordT   branchTarget
);

    wordT rsFwd;
    wordT rtFwd;
    wordT opB;
    logic rsEqRt;

    always_comb begin
        case (fwdA)
            FWD_MEM: rsFwd = memFwd;
            FWD_WB:  rsFwd = wbFwd;
            default: rsFwd = idEx.rsVal;
        endcase
        case (fwdB)
            FWD_MEM: rtFwd = memFwd;
            FWD_WB:  rtFwd = wbFwd;
            default: rtFwd = idEx.rtVal;
        endcase
    end

    assign opB      = idEx.useImm ? idEx.imm : rtFwd;
    assign storeVal = rtFwd;

    always_comb begin
        aluResult = '0;
        case (idEx.aluOp)
            ALU_ADD: aluResult = rsFwd + opB;
            ALU_SUB: aluResult = rsFwd - opB;
            ALU_AND: aluResult = rsFwd & opB;
            ALU_OR:  aluResult = rsFwd | opB;
            ALU_XOR: aluResult = rsFwd ^ opB;
            ALU_SLT: aluResult[0] = $signed(rsFwd) < $signed(opB);
            ALU_LUI: aluResult = opB;    // decoder already shifted the upper half
            default: aluResult = '0;
        endcase
    end

    // branches compare both forwarded registers, never the immediate
    assign rsEqRt       = (rsFwd == rtFwd);
    assign branchTaken  = (idEx.branchOp == BR_BEQ && rsEqRt) ||
                          (idEx.branchOp == BR_BNE && !rsEqRt);
    assign branchTarget = idEx.branchTarget;

endmodule

// ==== logic/fetchUnit.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetchUnit import cpuPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic stallF,
    input  logic branchTaken,
    input  wordT branchTarget,
    output wordT instrAddr
);

    wordT pc;
    wordT pcNext;

    always_comb begin
        if (branchTaken) begin
            pcNext = branchTarget;       // redirect beats a load-use hold
        end else if (stallF) begin
            pcNext = pc;
        end else begin
            pcNext = pc + wordT'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CPU_RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    assign instrAddr = pc;

    // branch targets come from the decoder's offset math
    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("fetch PC not word aligned: %h", pc);

endmodule

// ==== logic/hazardCtrl.sv ====
`timescale 1ns/1ps

module hazardCtrl import cpuPkg::*; (
    input  regIdxT idRs,
    input  regIdxT idRt,
    input  regIdxT exDest,
    input  logic   exRegWrite,
    input  logic   exIsLoad,
    input  regIdxT exRs,
    input  regIdxT exRt,
    input  regIdxT memDest,
    input  logic   memRegWrite,
    input  regIdxT wbDest,
    input  logic   wbRegWrite,
    input  logic   branchTaken,
    output logic   stallF,
    output logic   stallD,
    output logic   flushD,
    output logic   flushE,
    output fwdSelT fwdA,
    output fwdSelT fwdB
);

    logic loadUse;

    // decoder never sets regWrite for $0
    function automatic fwdSelT pickSource(input regIdxT src);
        if (memRegWrite && memDest == src) begin
            return FWD_MEM;   // youngest value wins
        end else if (wbRegWrite && wbDest == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwdA = pickSource(exRs);
        fwdB = pickSource(exRt);
    end

    // rt is compared for I-type ops too
    assign loadUse = exIsLoad && exRegWrite && (exDest == idRs || exDest == idRt);

    assign stallF = loadUse && !branchTaken;
    assign stallD = loadUse && !branchTaken;
    assign flushD = branchTaken;
    assign flushE = branchTaken || loadUse;   // bubble into ID/EX

endmodule

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder import cpuPkg::*; (
    input  wordT     instr,
    input  wordT     pc,
    output regIdxT   rsIdx,
    output regIdxT   rtIdx,
    output regIdxT   destIdx,
    output logic     regWrite,
    output wordT     imm,
    output wordT     branchTarget,
    output logic     useImm,
    output aluOpT    aluOp,
    output memOpT    memOp,
    output branchOpT branchOp
);

    wordT signImm;
    logic writesReg;

    assign rsIdx   = instr[25:21];
    assign rtIdx   = instr[20:16];
    assign signImm = wordT'($signed(instr[15:0]));

    // no delay slot, offset is relative to pc+4
    assign branchTarget = pc + wordT'(4) + (signImm << 2);

    always_comb begin
        destIdx   = instr[20:16];
        writesReg = 1'b0;
        imm       = signImm;
        useImm    = 1'b0;
        aluOp     = ALU_ADD;
        memOp     = MEM_NONE;
        branchOp  = BR_NONE;
        case (instr[31:26])
            OP_SPECIAL: begin
                destIdx   = instr[15:11];
                writesReg = 1'b1;
                case (instr[5:0])
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    default: writesReg = 1'b0;   // unsupported, acts as nop
                endcase
            end
            OP_ADDIU: begin
                writesReg = 1'b1;
                useImm    = 1'b1;
            end
            OP_ORI: begin
                writesReg = 1'b1;
                useImm    = 1'b1;
                imm       = wordT'(instr[15:0]);   // zero extended
                aluOp     = ALU_OR;
            end
            OP_LUI: begin
                writesReg = 1'b1;
                useImm    = 1'b1;
                imm       = {instr[15:0], 16'h0000};
                aluOp     = ALU_LUI;
            end
            OP_LW, OP_LB, OP_LBU: begin
                writesReg = 1'b1;
                useImm    = 1'b1;
                memOp     = (instr[31:26] == OP_LW) ? MEM_LW :
                            (instr[31:26] == OP_LB) ? MEM_LB : MEM_LBU;
            end
            OP_SW, OP_SB: begin
                useImm = 1'b1;
                memOp  = (instr[31:26] == OP_SW) ? MEM_SW : MEM_SB;
            end
            OP_BEQ: branchOp = BR_BEQ;
            OP_BNE: branchOp = BR_BNE;
            default: ;
        endcase
    end

    // writes to $0 are dropped here so hazard logic never matches on it
    assign regWrite = writesReg && (destIdx != '0);

endmodule

// ==== logic/memAccess.sv ====
`timescale 1ns/1ps

module memAccess import cpuPkg::*; (
    input  exMemT      exMem,
    output logic       dataEn,
    output logic [3:0] dataWen,
    output wordT       dataAddr,
    output wordT       dataWdata,
    input  wordT       dataRdata,
    output wordT       result
);

    logic [1:0] byteOff;
    logic [7:0] loadByte;

    assign byteOff  = exMem.aluResult[1:0];
    assign dataAddr = exMem.aluResult;
    assign dataEn   = (exMem.memOp != MEM_NONE);

    always_comb begin
        case (exMem.memOp)
            MEM_SW: begin
                dataWen   = 4'b1111;
                dataWdata = exMem.storeVal;
            end
            MEM_SB: begin
                dataWen   = 4'b0001 << byteOff;   // little endian lanes
                dataWdata = {4{exMem.storeVal[7:0]}};
            end
            default: begin
                dataWen   = 4'b0000;
                dataWdata = exMem.storeVal;
            end
        endcase
    end

    assign loadByte = dataRdata[8*byteOff +: 8];

    always_comb begin
        case (exMem.memOp)
            MEM_LW:  result = dataRdata;
            MEM_LB:  result = wordT'($signed(loadByte));
            MEM_LBU: result = wordT'(loadByte);
            default: result = exMem.aluResult;   // alu ops and stores
        endcase
        if (exMem.memOp == MEM_LW || exMem.memOp == MEM_SW) begin
            wordAligned: assert (byteOff == 2'b00)
                else $error("misaligned word access at %h", dataAddr);
        end
    end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module regFile import cpuPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  regIdxT rsIdx,
    input  regIdxT rtIdx,
    output wordT   rsVal,
    output wordT   rtVal,
    input  logic   wrEn,
    input  regIdxT wrIdx,
    input  wordT   wrData
);

    wordT regs [1:`CPU_REG_COUNT-1];   // $0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrIdx != '0) begin
            regs[wrIdx] <= wrData;
        end
    end

    // write-first, so WB and ID can share a cycle
    assign rsVal = (rsIdx == '0) ? '0 :
                   (wrEn && wrIdx == rsIdx) ? wrData : regs[rsIdx];
    assign rtVal = (rtIdx == '0) ? '0 :
                   (wrEn && wrIdx == rtIdx) ? wrData : regs[rtIdx];

endmodule

// ==== logic/stageReg.sv ====
`timescale 1ns/1ps

module stageReg import cpuPkg::*; #(
    parameter type payloadT = wordT
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  logic    flush,
    input  payloadT bubble,
    input  payloadT dataIn,
    output payloadT dataOut
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            dataOut <= bubble;
        end else if (!stall) begin
            dataOut <= dataIn;
        end
    end

    // hazard unit must let a flush win over a stall
    stallFlushExclusive: assert property (@(posedge clk) disable iff (reset)
        !(stall && flush))
        else $error("stage register stalled and flushed in one cycle");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build with verilator, run, and decide from the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f all.f --top-module cpuTb -o cpuSim \
    && ./obj_dir/cpuSim | tee /dev/stderr | grep -qx "All checks passed" \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }
